// ==== include/pit_consts.svh ====
// Interval timer constants
`ifndef PIT_CONSTS_SVH
`define PIT_CONSTS_SVH

// Register bus data width
`define PIT_DATA_W 8

// Width of each channel counter
`define PIT_COUNT_W 16

// Channels behind the shared bus
`define PIT_NUM_CH 3

// Control word address
// Channel addresses run 0 to 2 below it
`define PIT_ADDR_CTRL 3

`endif

// ==== verilog/pit_bus_pkg.sv ====
// Register bus types
package pit_bus_pkg;

	// Access order field, control word bits 5:4
	// Zero is not an order but the counter latch command
	typedef enum logic [1:0] {
		ACC_LATCH   = 2'b00,
		ACC_LSB     = 2'b01,
		ACC_MSB     = 2'b10,
		ACC_LSB_MSB = 2'b11
	} pit_access_e;

endpackage

// ==== verilog/pit_count_pkg.sv ====
// Counting types
`include "pit_consts.svh"

package pit_count_pkg;

	// One channel count value
	typedef logic [`PIT_COUNT_W-1:0] pit_count_t;

	// Counting mode, control word bits 3:1
	// Only modes 0, 2 and 3 are supported
	// MODE_NONE holds the channel idle with out low
	typedef enum logic [2:0] {
		MODE_TERMINAL = 3'd0,
		MODE_NONE     = 3'd1,
		MODE_RATE     = 3'd2,
		MODE_SQUARE   = 3'd3
	} pit_mode_e;

	// Byte-load progress of a count write
	typedef enum logic [1:0] {
		LD_IDLE       = 2'd0,
		LD_WAIT_FIRST = 2'd1,
		LD_WAIT_MSB   = 2'd2,
		LD_DONE       = 2'd3
	} pit_load_state_e;

endpackage

// ==== verilog/pit_bus_decode.sv ====
// Interval timer bus decoder
`timescale 1ns/100ps
`include "pit_consts.svh"

module pit_bus_decode (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   cs_n,
	input  logic                                   rd_n,
	input  logic                                   wr_n,
	input  logic [1:0]                             addr,
	input  logic [`PIT_DATA_W-1:0]                 wdata,
	input  logic [`PIT_NUM_CH-1:0][`PIT_DATA_W-1:0] latch_byte,
	output logic [`PIT_DATA_W-1:0]                 rdata,
	output logic [`PIT_NUM_CH-1:0]                 ctrl_wr,
	output logic [`PIT_NUM_CH-1:0]                 latch_cmd,
	output logic [`PIT_NUM_CH-1:0]                 count_wr,
	output logic [`PIT_NUM_CH-1:0]                 rd_sel
);

	import pit_bus_pkg::*;

	logic                   wr_n_q;
	logic                   rd_n_q;
	logic                   wr_stb;
	logic                   rd_stb;
	logic                   ctrl_hit;
	logic [1:0]             ch_sel;
	pit_access_e            acc;
	logic [`PIT_DATA_W-1:0] read_mux;

	// Previous strobe levels for falling edge detect
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_n_q <= 1'b1;
			rd_n_q <= 1'b1;
		end else begin
			wr_n_q <= wr_n;
			rd_n_q <= rd_n;
		end
	end

	// One strobe per access, first low cycle only
	assign wr_stb = ~cs_n & ~wr_n & wr_n_q;
	assign rd_stb = ~cs_n & ~rd_n & rd_n_q;

	// Control word fields
	assign ctrl_hit = wr_stb & (addr == 2'(`PIT_ADDR_CTRL));
	assign ch_sel   = wdata[7:6];
	assign acc      = pit_access_e'(wdata[5:4]);

	// Per-channel strobes
	// Select value 3 matches no channel and drops the write
	for (genvar i = 0; i < `PIT_NUM_CH; i++) begin : g_strobe
		assign ctrl_wr[i]   = ctrl_hit & (ch_sel == 2'(i)) & (acc != ACC_LATCH);
		assign latch_cmd[i] = ctrl_hit & (ch_sel == 2'(i)) & (acc == ACC_LATCH);
		assign count_wr[i]  = wr_stb & (addr == 2'(i));
		assign rd_sel[i]    = rd_stb & (addr == 2'(i));
	end

	// Addressed channel's next read byte
	always_comb begin
		read_mux = '0;
		for (int i = 0; i < `PIT_NUM_CH; i++) begin
			if (addr == 2'(i)) begin
				read_mux = latch_byte[i];
			end
		end
	end

	// Read data, captured at the end of the read cycle
	// A read of the control address leaves it alone
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (rd_stb && (addr != 2'(`PIT_ADDR_CTRL))) begin
			rdata <= read_mux;
		end
	end

	// Bus master never drives both strobes in one access
	a_no_rd_wr_overlap : assert property (@(posedge clk) disable iff (!rst_n)
		!cs_n |-> !(!rd_n && !wr_n));

endmodule

// ==== verilog/pit_channel_regs.sv ====
// Interval timer channel registers
`timescale 1ns/100ps
`include "pit_consts.svh"

module pit_channel_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`PIT_DATA_W-1:0]  wdata,
	input  logic                    ctrl_wr,
	input  logic                    latch_cmd,
	input  logic                    count_wr,
	input  logic                    rd_sel,
	input  pit_count_pkg::pit_count_t cur_count,
	output pit_count_pkg::pit_mode_e  mode,
	output pit_count_pkg::pit_count_t count_value,
	output logic                    load_pulse,
	output logic                    mode_pulse,
	output logic [`PIT_DATA_W-1:0]  latch_byte
);

	import pit_bus_pkg::*;
	import pit_count_pkg::*;

	pit_access_e            access;
	pit_load_state_e        ld_state;
	pit_mode_e              mode_dec;
	logic [`PIT_DATA_W-1:0] cnt_lsb;
	logic [`PIT_DATA_W-1:0] cnt_msb;
	pit_count_t             latch_q;
	logic                   rd_msb;

	// Mode field decode, 7 aliases square wave
	always_comb begin
		case (wdata[3:1])
			3'd0:       mode_dec = MODE_TERMINAL;
			3'd2:       mode_dec = MODE_RATE;
			3'd3, 3'd7: mode_dec = MODE_SQUARE;
			default:    mode_dec = MODE_NONE;
		endcase
	end

	// Control word and count byte loading
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			access     <= ACC_LATCH;
			mode       <= MODE_NONE;
			ld_state   <= LD_IDLE;
			cnt_lsb    <= '0;
			cnt_msb    <= '0;
			load_pulse <= 1'b0;
			mode_pulse <= 1'b0;
		end else begin
			load_pulse <= 1'b0;
			mode_pulse <= 1'b0;
			if (ctrl_wr) begin
				// New control word restarts the byte sequence
				access     <= pit_access_e'(wdata[5:4]);
				mode       <= mode_dec;
				ld_state   <= LD_WAIT_FIRST;
				mode_pulse <= 1'b1;
			end else if (count_wr) begin
				case (ld_state)
					LD_WAIT_FIRST, LD_DONE: begin
						case (access)
							ACC_LSB: begin
								cnt_lsb    <= wdata;
								cnt_msb    <= '0;
								ld_state   <= LD_DONE;
								load_pulse <= 1'b1;
							end
							ACC_MSB: begin
								cnt_lsb    <= '0;
								cnt_msb    <= wdata;
								ld_state   <= LD_DONE;
								load_pulse <= 1'b1;
							end
							ACC_LSB_MSB: begin
								// Hold off the load until the MSB
								cnt_lsb  <= wdata;
								ld_state <= LD_WAIT_MSB;
							end
							default: begin
								ld_state <= ld_state;
							end
						endcase
					end
					LD_WAIT_MSB: begin
						cnt_msb    <= wdata;
						ld_state   <= LD_DONE;
						load_pulse <= 1'b1;
					end
					// No control word yet, count bytes ignored
					default: begin
						ld_state <= LD_IDLE;
					end
				endcase
			end
		end
	end

	assign count_value = {cnt_msb, cnt_lsb};

	// Counter latch and read byte pointer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			latch_q <= '0;
			rd_msb  <= 1'b0;
		end else begin
			if (latch_cmd) begin
				latch_q <= cur_count;
			end
			if (ctrl_wr) begin
				rd_msb <= 1'b0;
			end else if (rd_sel) begin
				rd_msb <= ~rd_msb;
			end
		end
	end

	// LSB first, then MSB
	assign latch_byte = rd_msb ? latch_q[`PIT_COUNT_W-1:`PIT_DATA_W] : latch_q[`PIT_DATA_W-1:0];

	// A load pulse always comes from the write of the last count byte
	a_load_after_write : assert property (@(posedge clk) disable iff (!rst_n)
		load_pulse |-> $past(count_wr));

endmodule

// ==== verilog/pit_down_counter.sv ====
// Interval timer down counter
`timescale 1ns/100ps
`include "pit_consts.svh"

module pit_down_counter (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      tick,
	input  logic                      gate,
	input  pit_count_pkg::pit_mode_e  mode,
	input  pit_count_pkg::pit_count_t count_value,
	input  logic                      load_pulse,
	input  logic                      mode_pulse,
	output logic                      out,
	output pit_count_pkg::pit_count_t cur_count
);

	import pit_count_pkg::*;

	pit_count_t count;
	pit_count_t count_d;
	pit_count_t load_value;
	pit_count_t eff_value;
	pit_count_t half_value;
	logic       pending;
	logic       active;
	logic       load_now;
	logic       step;
	logic       out_d;

	// Written zero stands for the full count
	assign eff_value  = (count_value == '0) ? '1 : count_value;
	// Half of the value being loaded on a load tick, else of the last one
	assign half_value = (load_now ? eff_value : load_value) >> 1;

	// First tick after a load takes the count, gate or not
	assign load_now = tick & pending;
	// Later ticks count only with gate high
	assign step     = tick & active & gate & ~pending;

	// Next count
	always_comb begin
		count_d = count;
		if (load_now) begin
			count_d = eff_value;
		end else if (step) begin
			if (count == '0) begin
				// Terminal count holds, periodic modes reload
				count_d = (mode == MODE_TERMINAL) ? count : load_value;
			end else begin
				count_d = count - 1'b1;
			end
		end
	end

	// Output level from the next count
	always_comb begin
		out_d = 1'b0;
		if (active || load_now) begin
			case (mode)
				MODE_TERMINAL: out_d = (count_d == '0);
				MODE_RATE:     out_d = (count_d != '0);
				// High half of the period, or forced high by gate low
				MODE_SQUARE:   out_d = !gate || (count_d > half_value);
				default:       out_d = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count      <= '0;
			load_value <= '0;
			pending    <= 1'b0;
			active     <= 1'b0;
			out        <= 1'b0;
		end else if (mode_pulse) begin
			// Control write parks the channel until the next load
			pending <= 1'b0;
			active  <= 1'b0;
			out     <= 1'b0;
		end else begin
			count <= count_d;
			out   <= out_d;
			if (load_now) begin
				load_value <= eff_value;
				active     <= 1'b1;
			end
			// Unsupported modes never arm a load
			if (load_pulse && (mode != MODE_NONE)) begin
				pending <= 1'b1;
			end else if (load_now) begin
				pending <= 1'b0;
			end
		end
	end

	assign cur_count = count;

	// Counting only ever moves down from the value last loaded
	a_count_bounded : assert property (@(posedge clk) disable iff (!rst_n)
		(active && !pending) |-> (count <= load_value));

endmodule

// ==== verilog/pit_top.sv ====
// Programmable interval timer top
`timescale 1ns/100ps
`include "pit_consts.svh"

module pit_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   cs_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic [1:0]             addr,
	input  logic [`PIT_DATA_W-1:0] wdata,
	output logic [`PIT_DATA_W-1:0] rdata,
	input  logic [`PIT_NUM_CH-1:0] gate,
	input  logic [`PIT_NUM_CH-1:0] tick,
	output logic [`PIT_NUM_CH-1:0] out
);

	import pit_count_pkg::*;

	// Per-channel bus strobes
	logic [`PIT_NUM_CH-1:0]                  ctrl_wr;
	logic [`PIT_NUM_CH-1:0]                  latch_cmd;
	logic [`PIT_NUM_CH-1:0]                  count_wr;
	logic [`PIT_NUM_CH-1:0]                  rd_sel;
	logic [`PIT_NUM_CH-1:0][`PIT_DATA_W-1:0] latch_byte;

	pit_bus_decode i_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.cs_n       (cs_n),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.addr       (addr),
		.wdata      (wdata),
		.latch_byte (latch_byte),
		.rdata      (rdata),
		.ctrl_wr    (ctrl_wr),
		.latch_cmd  (latch_cmd),
		.count_wr   (count_wr),
		.rd_sel     (rd_sel)
	);

	// One register block and one counter per channel
	for (genvar i = 0; i < `PIT_NUM_CH; i++) begin : g_ch
		pit_mode_e  mode;
		pit_count_t count_value;
		pit_count_t cur_count;
		logic       load_pulse;
		logic       mode_pulse;

		pit_channel_regs i_regs (
			.clk         (clk),
			.rst_n       (rst_n),
			.wdata       (wdata),
			.ctrl_wr     (ctrl_wr[i]),
			.latch_cmd   (latch_cmd[i]),
			.count_wr    (count_wr[i]),
			.rd_sel      (rd_sel[i]),
			.cur_count   (cur_count),
			.mode        (mode),
			.count_value (count_value),
			.load_pulse  (load_pulse),
			.mode_pulse  (mode_pulse),
			.latch_byte  (latch_byte[i])
		);

		pit_down_counter i_counter (
			.clk         (clk),
			.rst_n       (rst_n),
			.tick        (tick[i]),
			.gate        (gate[i]),
			.mode        (mode),
			.count_value (count_value),
			.load_pulse  (load_pulse),
			.mode_pulse  (mode_pulse),
			.out         (out[i]),
			.cur_count   (cur_count)
		);
	end

endmodule

// ==== tb/pit_tb.sv ====
// Interval timer directed testbench
`timescale 1ns/100ps
`include "pit_consts.svh"

module pit_tb;

	localparam int CLK_PERIOD = 8;
	localparam int DRIVE_DLY  = 1;
	localparam int RESET_CYC  = 16;
	// Idle cycles after each access or tick, five cycles per operation
	localparam int GAP_CYC    = 3;
	// Worst case near 1400 ticks and 50 accesses, about 7000 cycles, taken about three times
	localparam int MAX_CYCLES = 20000;
	localparam int M_TERMINAL = 0;
	localparam int M_RATE     = 2;
	localparam int M_SQUARE   = 3;
	localparam logic [1:0] A_LSB  = 2'b01;
	localparam logic [1:0] A_MSB  = 2'b10;
	localparam logic [1:0] A_BOTH = 2'b11;

	logic                   clk, rst_n, cs_n, rd_n, wr_n;
	logic [1:0]             addr;
	logic [`PIT_DATA_W-1:0] wdata, rdata;
	logic [`PIT_NUM_CH-1:0] gate, tick, out;

	// Reference model, one entry per channel
	int          m_mode [`PIT_NUM_CH];
	int          m_written [`PIT_NUM_CH];
	int          m_load [`PIT_NUM_CH];
	int          m_count [`PIT_NUM_CH];
	bit          m_pending [`PIT_NUM_CH];
	bit          m_active [`PIT_NUM_CH];
	int          errors, checks, cycle_count;
	logic [31:0] rng_state;

	pit_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: simulation ran past %0d clock cycles", MAX_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// Expected out level from the counting rules
	function automatic logic model_out(input int ch);
		logic level;
		level = 1'b0;
		if (m_active[ch]) begin
			case (m_mode[ch])
				M_TERMINAL: level = (m_count[ch] == 0);
				M_RATE:     level = (m_count[ch] != 0);
				M_SQUARE:   level = !gate[ch] || (m_count[ch] > m_load[ch] / 2);
				default:    level = 1'b0;
			endcase
		end
		return level;
	endfunction

	task automatic check_out(input string name, input int ch);
		check_value(name, 32'(model_out(ch)), 32'(out[ch]));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	task automatic draw_rand(input int span, output int value);
		rng_state = xorshift32(rng_state);
		value = int'(rng_state % 32'(span));
	endtask

	// First tick after a load takes the count, later ticks count with gate high
	task automatic model_tick(input int ch);
		if (m_pending[ch]) begin
			m_load[ch]    = (m_written[ch] == 0) ? 65535 : m_written[ch];
			m_count[ch]   = m_load[ch];
			m_active[ch]  = 1'b1;
			m_pending[ch] = 1'b0;
		end else if (m_active[ch] && gate[ch]) begin
			if (m_count[ch] != 0)
				m_count[ch] = m_count[ch] - 1;
			else if (m_mode[ch] != M_TERMINAL)
				m_count[ch] = m_load[ch];
		end
	endtask

	task automatic bus_write(input logic [1:0] a, input logic [`PIT_DATA_W-1:0] d);
		@(posedge clk);
		#DRIVE_DLY;
		{cs_n, wr_n, addr, wdata} = {2'b00, a, d};
		@(posedge clk);
		#DRIVE_DLY;
		{cs_n, wr_n} = 2'b11;
		repeat (GAP_CYC) @(posedge clk);
	endtask

	// Read data is registered on the strobe cycle
	task automatic bus_read(input logic [1:0] a, output logic [`PIT_DATA_W-1:0] d);
		@(posedge clk);
		#DRIVE_DLY;
		{cs_n, rd_n, addr} = {2'b00, a};
		@(posedge clk);
		#DRIVE_DLY;
		{cs_n, rd_n} = 2'b11;
		d = rdata;
		repeat (GAP_CYC) @(posedge clk);
	endtask

	task automatic pulse_tick(input int ch);
		@(posedge clk);
		#DRIVE_DLY;
		tick[ch] = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		tick[ch] = 1'b0;
		model_tick(ch);
		repeat (GAP_CYC) @(posedge clk);
	endtask

	task automatic drive_gate(input int ch, input logic level);
		@(posedge clk);
		#DRIVE_DLY;
		gate[ch] = level;
		repeat (GAP_CYC) @(posedge clk);
	endtask

	// Control word restarts the channel idle
	task automatic program_channel(input int ch, input int mode, input logic [1:0] acc);
		bus_write(2'(`PIT_ADDR_CTRL), {2'(ch), acc, 3'(mode), 1'b0});
		m_mode[ch]    = mode;
		m_pending[ch] = 1'b0;
		m_active[ch]  = 1'b0;
	endtask

	// Single-byte orders clear the other byte
	task automatic write_count(input int ch, input logic [1:0] acc, input logic [15:0] value);
		if (acc != A_MSB)
			bus_write(2'(ch), value[7:0]);
		if (acc != A_LSB)
			bus_write(2'(ch), value[15:8]);
		m_written[ch] = (acc == A_LSB) ? int'(value[7:0]) :
			(acc == A_MSB) ? int'({value[15:8], 8'h00}) : int'(value);
		m_pending[ch] = 1'b1;
	endtask

	task automatic send_latch(input int ch);
		bus_write(2'(`PIT_ADDR_CTRL), {2'(ch), 6'b000000});
	endtask

	task automatic read_latched(input int ch, output logic [15:0] value);
		logic [7:0] lo;
		logic [7:0] hi;
		bus_read(2'(ch), lo);
		bus_read(2'(ch), hi);
		value = {hi, lo};
	endtask

	task automatic test_reset();
		logic [15:0] value;
		check_value("reset out", 32'h0, 32'(out));
		for (int ch = 0; ch < `PIT_NUM_CH; ch++) begin
			send_latch(ch);
			read_latched(ch, value);
			check_value("reset latch", 32'h0, 32'(value));
		end
	endtask

	task automatic test_mode0();
		int n;
		draw_rand(38, n);
		n = n + 2;
		program_channel(0, M_TERMINAL, A_BOTH);
		write_count(0, A_BOTH, 16'(n));
		check_out("mode0 before load", 0);
		for (int i = 0; i <= n; i++) begin
			pulse_tick(0);
			check_out("mode0 out", 0);
		end
		check_value("mode0 terminal out", 32'h1, 32'(out[0]));
	endtask

	task automatic test_mode2();
		int n;
		int lows;
		draw_rand(8, n);
		n = n + 3;
		// Leave a nonzero MSB behind for the LSB-only write to clear
		program_channel(1, M_RATE, A_MSB);
		write_count(1, A_MSB, 16'h0300);
		program_channel(1, M_RATE, A_LSB);
		write_count(1, A_LSB, {8'h00, 8'(n)});
		pulse_tick(1);
		check_out("mode2 load", 1);
		lows = 0;
		for (int i = 0; i < 3 * (n + 1); i++) begin
			pulse_tick(1);
			check_out("mode2 out", 1);
			if (out[1] == 1'b0)
				lows++;
		end
		check_value("mode2 low ticks", 32'd3, 32'(lows));
	endtask

	task automatic test_mode3();
		int msb;
		int ticks;
		draw_rand(2, msb);
		msb = msb + 1;
		// Leave a nonzero LSB behind for the MSB-only write to clear
		program_channel(2, M_SQUARE, A_LSB);
		write_count(2, A_LSB, 16'h003c);
		program_channel(2, M_SQUARE, A_MSB);
		write_count(2, A_MSB, {8'(msb), 8'h3c});
		// Two full periods, then into the low half
		ticks = 1 + 2 * (msb * 256 + 1) + msb * 128 + 4;
		for (int i = 0; i < ticks; i++) begin
			pulse_tick(2);
			check_out("mode3 out", 2);
		end
		drive_gate(2, 1'b0);
		check_value("mode3 gate low out", 32'h1, 32'(out[2]));
		for (int i = 0; i < 4; i++) begin
			pulse_tick(2);
			check_out("mode3 gate low hold", 2);
		end
		drive_gate(2, 1'b1);
		check_out("mode3 gate restored", 2);
	endtask

	task automatic test_latch();
		int base;
		int latched;
		logic [15:0] value;
		draw_rand(256, base);
		program_channel(0, M_RATE, A_BOTH);
		write_count(0, A_BOTH, 16'(256 + base));
		repeat (6) pulse_tick(0);
		latched = m_count[0];
		send_latch(0);
		repeat (3) pulse_tick(0);
		read_latched(0, value);
		check_value("latch lsb", latched & 255, 32'(value[7:0]));
		check_value("latch msb", (latched >> 8) & 255, 32'(value[15:8]));
	endtask

	task automatic test_gate();
		logic [15:0] value;
		drive_gate(0, 1'b0);
		repeat (5) pulse_tick(0);
		send_latch(0);
		read_latched(0, value);
		check_value("gate low count", 32'(m_count[0]), 32'(value));
		drive_gate(0, 1'b1);
		// Gate low forces channel 2 out high
		drive_gate(2, 1'b0);
		// Reprogramming channel 0 must not touch channels 1 and 2
		program_channel(0, M_TERMINAL, A_LSB);
		write_count(0, A_LSB, 16'h0004);
		check_out("other channel 1 out", 1);
		check_out("other channel 2 out", 2);
		check_out("reprogram out0", 0);
		repeat (5) pulse_tick(0);
		check_out("reprogram terminal", 0);
	endtask

	initial begin
		{cs_n, rd_n, wr_n} = 3'b111;
		addr      = '0;
		wdata     = '0;
		gate      = '1;
		tick      = '0;
		rst_n     = 1'b0;
		rng_state = 32'h0a181412;
		for (int ch = 0; ch < `PIT_NUM_CH; ch++) begin
			m_mode[ch]    = -1;
			m_written[ch] = 0;
			m_load[ch]    = 0;
			m_count[ch]   = 0;
			m_pending[ch] = 1'b0;
			m_active[ch]  = 1'b0;
		end
		repeat (RESET_CYC) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		repeat (GAP_CYC) @(posedge clk);
		test_reset();
		test_mode0();
		test_mode2();
		test_mode3();
		test_latch();
		test_gate();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+include
verilog/pit_bus_pkg.sv
verilog/pit_count_pkg.sv
verilog/pit_bus_decode.sv
verilog/pit_channel_regs.sv
verilog/pit_down_counter.sv
verilog/pit_top.sv
tb/pit_tb.sv

// ==== Makefile ====
# Verilator build and run for the interval timer
TOP             ?= pit_tb
LOG             ?= sim.log
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
FILE_LIST       := sim.f
SOURCES         := $(shell grep -v '^+' $(FILE_LIST)) include/pit_consts.svh
BIN             := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides the result
run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
